// ==== build.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
hazardIf.sv
pipeReg.sv
decodeUnit.sv
execUnit.sv
hazardUnit.sv
mipsCore.sv
tbMipsCore.sv

// ==== cpuMacros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define XLEN        32  // data and address width
`define REG_ADDR_W  5
`define REG_COUNT   32

//////////////////////////////
// memory map
//////////////////////////////

`define RESET_PC    32'h0000_0000
`define IMEM_WORDS  256  // instruction ROM depth in words

`endif

// ==== decodeUnit.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module decodeUnit (
    input  logic              clk,
    input  logic              reset,
    input  pipePkg::fetchDecT fd,
    input  isaPkg::regAddrT   writeAddrW,
    input  isaPkg::wordT      writeDataW,
    input  logic              regWriteW,
    input  isaPkg::wordT      aluResM,
    hazardIf.core             hz,
    output pipePkg::decExT    de,
    output logic              pcRedirect,
    output isaPkg::wordT      pcTarget,
    output logic              jump,
    output logic              branch,
    output logic              aluSrc
);
    import isaPkg::*;
    import pipePkg::*;

    opcodeT  opcode;
    functT   funct;
    regAddrT rs, rt, rd;
    ctrlT    ctrl;
    logic    zeroImm;
    wordT    regs [`REG_COUNT];
    wordT    rd1, rd2, immExt, cmpA, cmpB;

    assign opcode = opcodeT'(fd.instr[31:26]);
    assign funct  = functT'(fd.instr[5:0]);
    assign rs     = fd.instr[25:21];
    assign rt     = fd.instr[20:16];
    assign rd     = fd.instr[15:11];

    //////////////////////////////
    // control decode
    //////////////////////////////

    always_comb
    begin
        ctrl    = '0;
        branch  = 1'b0;
        jump    = 1'b0;
        zeroImm = 1'b0;
        case (opcode)
            opRtype:
            begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl.regWrite = 1'b0;  // nop, incl. all-zero bubble
                endcase
            end
            opLw:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opSw:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opAddi:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opAndi, opOri:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = (opcode == opAndi) ? aluAnd : aluOr;
                zeroImm       = 1'b1;
            end
            opBeq:   branch = 1'b1;
            opJ:     jump = 1'b1;
            opHalt:  ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

    assign aluSrc = ctrl.aluSrc;

    //////////////////////////////
    // register file
    //////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (regWriteW && writeAddrW != '0)  // r0 stays zero
            regs[writeAddrW] <= writeDataW;
    end

    // same-cycle writeback bypass
    assign rd1 = (regWriteW && writeAddrW != '0 && writeAddrW == rs) ? writeDataW : regs[rs];
    assign rd2 = (regWriteW && writeAddrW != '0 && writeAddrW == rt) ? writeDataW : regs[rt];

    assign immExt = zeroImm ? {{(`XLEN-16){1'b0}}, fd.instr[15:0]}
                            : {{(`XLEN-16){fd.instr[15]}}, fd.instr[15:0]};

    // beq resolved here, memory result forwarded in
    assign cmpA = hz.forwardAD ? aluResM : rd1;
    assign cmpB = hz.forwardBD ? aluResM : rd2;

    assign pcTarget   = jump ? {fd.pcPlus4[31:28], fd.instr[25:0], 2'b00}
                             : fd.pcPlus4 + {immExt[29:0], 2'b00};
    assign pcRedirect = ((branch && cmpA == cmpB) || jump) && !hz.stallD;

    always_comb
    begin
        de.ctrl      = ctrl;
        de.regData1  = rd1;
        de.regData2  = rd2;
        de.immExt    = immExt;
        de.rs        = rs;
        de.rt        = rt;
        de.writeAddr = (opcode == opRtype) ? rd : rt;
    end

    // r0 reads as zero on both ports, bypass included
    assert property (@(posedge clk) disable iff (reset)
        (rs == '0) |-> (rd1 == '0));
    assert property (@(posedge clk) disable iff (reset)
        (rt == '0) |-> (rd2 == '0));

endmodule

// ==== execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
    input  pipePkg::decExT de,
    input  isaPkg::wordT   aluResM,
    input  isaPkg::wordT   writeDataW,
    hazardIf.core          hz,
    output pipePkg::exMemT em
);
    import isaPkg::*;

    wordT srcA, regB, srcB;

    // operand forwarding, memory before writeback
    always_comb
    begin
        case (hz.forwardAE)
            2'b10:   srcA = aluResM;
            2'b01:   srcA = writeDataW;
            default: srcA = de.regData1;
        endcase
        case (hz.forwardBE)
            2'b10:   regB = aluResM;
            2'b01:   regB = writeDataW;
            default: regB = de.regData2;
        endcase
    end

    assign srcB = de.ctrl.aluSrc ? de.immExt : regB;

    always_comb
    begin
        em.ctrl      = de.ctrl;
        em.storeData = regB;      // forwarded rt is the sw data
        em.writeAddr = de.writeAddr;
        case (de.ctrl.aluOp)
            aluAdd:  em.aluRes = srcA + srcB;
            aluSub:  em.aluRes = srcA - srcB;
            aluAnd:  em.aluRes = srcA & srcB;
            aluOr:   em.aluRes = srcA | srcB;
            aluSlt:  em.aluRes = ($signed(srcA) < $signed(srcB)) ? wordT'(1) : '0;
            default: em.aluRes = srcA + srcB;
        endcase
    end

endmodule

// ==== hazardIf.sv ====
`timescale 1ns/1ps

interface hazardIf (
    input logic clk,
    input logic reset
);
    import isaPkg::*;

    regAddrT    rsD, rtD;                       // decode sources
    logic       aluSrcD, branchD, jumpD;
    regAddrT    rsE, rtE, writeAddrE;
    logic       regWriteE, memToRegE;
    regAddrT    writeAddrM;
    logic       regWriteM, memToRegM;
    regAddrT    writeAddrW;
    logic       regWriteW;
    logic       haltPending;

    logic [1:0] forwardAE, forwardBE;           // 00 none, 01 writeback, 10 memory
    logic       forwardAD, forwardBD;           // memory result into branch compare
    logic       stallF, stallD, flushE;

    modport hazard (
        input  clk, reset,
        input  rsD, rtD, aluSrcD, branchD, jumpD,
        input  rsE, rtE, writeAddrE, regWriteE, memToRegE,
        input  writeAddrM, regWriteM, memToRegM,
        input  writeAddrW, regWriteW, haltPending,
        output forwardAE, forwardBE, forwardAD, forwardBD,
        output stallF, stallD, flushE
    );

    modport core (
        output rsD, rtD, aluSrcD, branchD, jumpD,
        output rsE, rtE, writeAddrE, regWriteE, memToRegE,
        output writeAddrM, regWriteM, memToRegM,
        output writeAddrW, regWriteW, haltPending,
        input  forwardAE, forwardBE, forwardAD, forwardBD,
        input  stallF, stallD, flushE
    );

endinterface

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    hazardIf.hazard hz
);
    import isaPkg::*;

    logic loadUseStall, branchStall, rtUsedD;

    // memory has priority, r0 never forwarded
    function automatic logic [1:0] fwdSel(input regAddrT src);
        if (src != '0 && hz.regWriteM && src == hz.writeAddrM)
            return 2'b10;
        else if (src != '0 && hz.regWriteW && src == hz.writeAddrW)
            return 2'b01;
        else
            return 2'b00;
    endfunction

    assign hz.forwardAE = fwdSel(hz.rsE);
    assign hz.forwardBE = fwdSel(hz.rtE);

    assign hz.forwardAD = (hz.rsD != '0) && hz.regWriteM && (hz.rsD == hz.writeAddrM);
    assign hz.forwardBD = (hz.rtD != '0) && hz.regWriteM && (hz.rtD == hz.writeAddrM);

    assign rtUsedD = !hz.aluSrcD;

    assign loadUseStall = hz.memToRegE &&
        ((hz.rsD == hz.writeAddrE) || (rtUsedD && hz.rtD == hz.writeAddrE));

    // beq waits for an ALU result in execute or a load in memory
    assign branchStall = hz.branchD &&
        ((hz.regWriteE && (hz.writeAddrE == hz.rsD || hz.writeAddrE == hz.rtD)) ||
         (hz.memToRegM && (hz.writeAddrM == hz.rsD || hz.writeAddrM == hz.rtD)));

    assign hz.stallF = loadUseStall || branchStall || hz.haltPending;
    assign hz.stallD = loadUseStall || branchStall || hz.haltPending;
    assign hz.flushE = loadUseStall || branchStall || hz.jumpD;

    assert property (@(posedge hz.clk) disable iff (hz.reset)
        (hz.forwardAE != 2'b00) |-> (hz.rsE != '0));
    assert property (@(posedge hz.clk) disable iff (hz.reset)
        (hz.forwardBE != 2'b00) |-> (hz.rtE != '0));

    // load-use stall means a load in memory never feeds execute
    assert property (@(posedge hz.clk) disable iff (hz.reset)
        (hz.forwardAE == 2'b10 || hz.forwardBE == 2'b10) |-> !hz.memToRegM);

endmodule

// ==== isaPkg.sv ====
`include "cpuMacros.svh"

package isaPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opRtype = 6'b000000,
        opJ     = 6'b000010,
        opBeq   = 6'b000100,
        opAddi  = 6'b001000,
        opAndi  = 6'b001100,
        opOri   = 6'b001101,
        opHalt  = 6'b001110,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    // function field of register instructions
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } functT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,  // zero so a bubble decodes as add
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    typedef logic [`REG_ADDR_W-1:0] regAddrT;
    typedef logic [`XLEN-1:0]       wordT;

endpackage

// ==== mipsCore.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module mipsCore (
    input  logic         clk,
    input  logic         reset,
    input  isaPkg::wordT imemData,
    input  isaPkg::wordT dmemReadData,
    output isaPkg::wordT imemAddr,
    output isaPkg::wordT dmemAddr,
    output isaPkg::wordT dmemWriteData,
    output logic         dmemWriteEnable,
    output logic         halt
);
    import isaPkg::*;
    import pipePkg::*;

    wordT     pc, pcTarget, writeDataW;
    logic     pcRedirect, jumpD, branchD, aluSrcD;
    fetchDecT fdIn, fdQ;
    decExT    deD, deQ;
    exMemT    emD, emQ;
    memWbT    mwD, mwQ;

    hazardIf hz (.clk(clk), .reset(reset));

    hazardUnit hazard (.hz(hz.hazard));

    //////////////////////////////
    // fetch
    //////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pc <= `RESET_PC;
        else if (pcRedirect)
            pc <= pcTarget;
        else if (!hz.stallF)
            pc <= pc + wordT'(4);
    end

    assign imemAddr     = pc;
    assign fdIn.instr   = imemData;
    assign fdIn.pcPlus4 = pc + wordT'(4);

    // no delay slot, a redirect squashes the fetched word
    pipeReg #(.payloadT(fetchDecT)) fdReg (
        .clk(clk), .reset(reset), .stall(hz.stallD), .flush(pcRedirect), .d(fdIn), .q(fdQ)
    );

    //////////////////////////////
    // decode and execute
    //////////////////////////////

    decodeUnit decode (
        .clk(clk), .reset(reset), .fd(fdQ),
        .writeAddrW(mwQ.writeAddr), .writeDataW(writeDataW), .regWriteW(mwQ.ctrl.regWrite),
        .aluResM(emQ.aluRes), .hz(hz.core), .de(deD),
        .pcRedirect(pcRedirect), .pcTarget(pcTarget),
        .jump(jumpD), .branch(branchD), .aluSrc(aluSrcD)
    );

    pipeReg #(.payloadT(decExT)) deReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(hz.flushE), .d(deD), .q(deQ)
    );

    execUnit execute (
        .de(deQ), .aluResM(emQ.aluRes), .writeDataW(writeDataW), .hz(hz.core), .em(emD)
    );

    pipeReg #(.payloadT(exMemT)) emReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(emD), .q(emQ)
    );

    //////////////////////////////
    // memory and writeback
    //////////////////////////////

    assign dmemAddr        = emQ.aluRes;
    assign dmemWriteData   = emQ.storeData;
    assign dmemWriteEnable = emQ.ctrl.memWrite;

    assign mwD.ctrl      = emQ.ctrl;
    assign mwD.aluRes    = emQ.aluRes;
    assign mwD.loadData  = dmemReadData;
    assign mwD.writeAddr = emQ.writeAddr;

    pipeReg #(.payloadT(memWbT)) mwReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(mwD), .q(mwQ)
    );

    assign writeDataW = mwQ.ctrl.memToReg ? mwQ.loadData : mwQ.aluRes;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            halt <= 1'b0;
        else if (mwQ.ctrl.halt)
            halt <= 1'b1;  // sticky until reset
    end

    // hazard inputs
    assign hz.rsD        = deD.rs;
    assign hz.rtD        = deD.rt;
    assign hz.aluSrcD    = aluSrcD && !deD.ctrl.memWrite;  // a store still reads rt as data
    assign hz.branchD    = branchD;
    assign hz.jumpD      = jumpD;
    assign hz.rsE        = deQ.rs;
    assign hz.rtE        = deQ.rt;
    assign hz.writeAddrE = deQ.writeAddr;
    assign hz.regWriteE  = deQ.ctrl.regWrite;
    assign hz.memToRegE  = deQ.ctrl.memToReg;
    assign hz.writeAddrM = emQ.writeAddr;
    assign hz.regWriteM  = emQ.ctrl.regWrite;
    assign hz.memToRegM  = emQ.ctrl.memToReg;
    assign hz.writeAddrW = mwQ.writeAddr;
    assign hz.regWriteW  = mwQ.ctrl.regWrite;

    // halt anywhere from decode on, or already retired
    assign hz.haltPending = deD.ctrl.halt || deQ.ctrl.halt || emQ.ctrl.halt ||
                            mwQ.ctrl.halt || halt;

endmodule

// ==== pipePkg.sv ====
package pipePkg;
    import isaPkg::*;

    // all zero is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrc;
        logic  halt;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        wordT instr;
        wordT pcPlus4;
    } fetchDecT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    regData1;
        wordT    regData2;
        wordT    immExt;
        regAddrT rs;
        regAddrT rt;
        regAddrT writeAddr;
    } decExT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    aluRes;
        wordT    storeData;
        regAddrT writeAddr;
    } exMemT;

    // only regWrite, memToReg and halt matter past memory
    typedef struct packed {
        ctrlT    ctrl;
        wordT    aluRes;
        wordT    loadData;
        regAddrT writeAddr;
    } memWbT;

endpackage

// ==== pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            q <= '0;
        else if (flush)
            q <= '0;  // bubble, wins over stall
        else if (!stall)
            q <= d;
    end

    // a stalled stage keeps its instruction for the next cycle
    assert property (@(posedge clk) disable iff (reset)
        (stall && !flush) |=> (q == $past(q)));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the MIPS core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbMipsCore -f build.f -o simMips
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/simMips > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "FAIL: see sim.log"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "FAIL: no pass line in sim.log"
    exit 1
fi
echo "PASS"
exit 0

// ==== tbMipsCore.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module tbMipsCore;
    import isaPkg::*;

    logic clk = 1'b0;
    logic reset;
    wordT imemData, dmemReadData, imemAddr, dmemAddr, dmemWriteData;
    logic dmemWriteEnable, halt;

    wordT rom [`IMEM_WORDS];
    wordT ram [64];
    wordT ramInit [64];
    wordT expAddr [$];
    wordT expData [$];
    int   pcIdx, steps, storeIdx, valueErrs, otherErrs;
    bit   modelReady, finished;

    always #2 clk = ~clk;  // 4 ns period

    mipsCore dut (
        .clk(clk), .reset(reset), .imemData(imemData), .dmemReadData(dmemReadData),
        .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
        .dmemWriteEnable(dmemWriteEnable), .halt(halt)
    );

    //////////////////////////////
    // memories
    //////////////////////////////

    assign imemData     = rom[imemAddr[9:2]];
    assign dmemReadData = ram[dmemAddr[7:2]];

    always @(posedge clk)
    begin
        if (dmemWriteEnable)
            ram[dmemAddr[7:2]] <= dmemWriteData;
    end

    //////////////////////////////
    // assembler
    //////////////////////////////

    function automatic wordT encR(functT fn, int rd, int rs, int rt);
        return {opRtype, regAddrT'(rs), regAddrT'(rt), regAddrT'(rd), 5'b0, fn};
    endfunction

    function automatic wordT encI(opcodeT op, int rs, int rt, logic [15:0] imm);
        return {op, regAddrT'(rs), regAddrT'(rt), imm};
    endfunction

    task automatic emit(input wordT w);
        rom[pcIdx] = w;
        pcIdx++;
    endtask

    task automatic assembleProgram();
        logic [15:0] imm1, imm2, imm3, imm4, imm5;
        int p;
        imm1 = 16'($urandom);
        imm2 = 16'($urandom);
        if (imm2 == imm1)
            imm2 = imm1 + 16'd1;  // keeps r1 != r2 for the not-taken beq
        imm3 = 16'($urandom);
        imm4 = 16'($urandom);
        imm5 = 16'($urandom);
        for (int i = 0; i < `IMEM_WORDS; i++)
            rom[i] = {opHalt, 10'b0, 16'(i)};
        pcIdx = 0;
        // dependent ALU chain
        emit(encI(opAddi, 0, 1, imm1));
        emit(encI(opAddi, 0, 2, imm2));
        emit(encR(fnAdd, 3, 1, 2));
        emit(encR(fnSub, 4, 3, 1));
        emit(encR(fnAnd, 5, 4, 3));
        emit(encR(fnOr, 6, 5, 4));
        emit(encR(fnSlt, 7, 6, 5));
        emit(encR(fnSlt, 8, 2, 1));
        emit(encI(opAndi, 6, 9, imm3));
        emit(encI(opOri, 9, 10, imm4));
        emit(encI(opAddi, 10, 11, imm5));
        for (int k = 3; k <= 11; k++)
            emit(encI(opSw, 0, k, 16'(32'h40 + 4 * (k - 3))));
        // load-use
        emit(encI(opLw, 0, 12, 16'h0000));
        emit(encR(fnAdd, 13, 12, 1));
        emit(encI(opLw, 0, 14, 16'h0004));
        emit(encI(opSw, 0, 14, 16'h0064));
        emit(encI(opSw, 0, 13, 16'h0068));
        // branches
        emit(encI(opLw, 0, 15, 16'h0008));
        emit(encI(opBeq, 15, 15, 16'd1));  // taken, source from load
        emit(encI(opSw, 0, 1, 16'h006c));
        emit(encI(opAddi, 15, 16, 16'd0));
        emit(encI(opBeq, 16, 15, 16'd1));  // taken, source from ALU
        emit(encI(opSw, 0, 2, 16'h0070));
        emit(encR(fnSub, 17, 1, 2));
        emit(encI(opBeq, 17, 0, 16'd1));   // not taken
        emit(encI(opSw, 0, 17, 16'h0074));
        emit(encI(opLw, 0, 18, 16'h000c));
        emit(encI(opBeq, 18, 1, 16'd1));   // direction set by random data
        emit(encI(opSw, 0, 18, 16'h0078));
        // jump over two stores
        p = pcIdx;
        emit({opJ, 26'(p + 3)});
        emit(encI(opSw, 0, 1, 16'h007c));
        emit(encI(opSw, 0, 2, 16'h0080));
        emit(encI(opSw, 0, 11, 16'h0084));
        emit({opHalt, 26'b0});
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // runs the program architecturally, fills the expected store queues
    function automatic int refModel();
        wordT    r [`REG_COUNT];
        wordT    mem [64];
        wordT    pc, instr, sext, zext, ea, a, b, nextPc;
        regAddrT rs, rt, rd;
        int      n;
        bit      stop;
        for (int i = 0; i < `REG_COUNT; i++)
            r[i] = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = ramInit[i];
        pc = `RESET_PC;
        n = 0;
        stop = 1'b0;
        while (!stop && n < 1000)
        begin
            instr  = rom[pc[9:2]];
            rs     = instr[25:21];
            rt     = instr[20:16];
            rd     = instr[15:11];
            sext   = {{16{instr[15]}}, instr[15:0]};
            zext   = {16'b0, instr[15:0]};
            a      = r[rs];
            b      = r[rt];
            nextPc = pc + 32'd4;
            n++;
            case (instr[31:26])
                opRtype:
                    case (instr[5:0])
                        fnAdd:   r[rd] = a + b;
                        fnSub:   r[rd] = a - b;
                        fnAnd:   r[rd] = a & b;
                        fnOr:    r[rd] = a | b;
                        fnSlt:   r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                opAddi:  r[rt] = a + sext;
                opAndi:  r[rt] = a & zext;
                opOri:   r[rt] = a | zext;
                opLw:
                begin
                    ea = a + sext;
                    r[rt] = mem[ea[7:2]];
                end
                opSw:
                begin
                    ea = a + sext;
                    mem[ea[7:2]] = b;
                    expAddr.push_back(ea);
                    expData.push_back(b);
                end
                opBeq:   if (a == b) nextPc = pc + 32'd4 + {sext[29:0], 2'b00};
                opJ:     nextPc = {nextPc[31:28], instr[25:0], 2'b00};
                opHalt:  stop = 1'b1;
                default: ;
            endcase
            r[0] = '0;
            pc = nextPc;
        end
        return n;
    endfunction

    task automatic reportMismatch(input string name, input wordT got, input wordT exp);
        valueErrs++;
        $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    //////////////////////////////
    // checker
    //////////////////////////////

    always @(posedge clk)
    begin
        if (!reset && dmemWriteEnable)
        begin
            if (storeIdx >= expAddr.size())
            begin
                otherErrs++;
                $display("unexpected store to %h beyond the expected list", dmemAddr);
            end
            else
            begin
                if (dmemAddr !== expAddr[storeIdx])
                    reportMismatch("dmemAddr", dmemAddr, expAddr[storeIdx]);
                if (dmemWriteData !== expData[storeIdx])
                    reportMismatch("dmemWriteData", dmemWriteData, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    initial
    begin
        void'($urandom(28));
        reset = 1'b1;
        for (int i = 0; i < 64; i++)
            ramInit[i] = (i < 16) ? $urandom : (32'hA5C3_0000 ^ (32'(i) * 32'h0101_0101));
        for (int i = 0; i < 64; i++)
            ram[i] = ramInit[i];
        assembleProgram();
        steps = refModel();
        modelReady = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // state right after reset
        if (dmemWriteEnable !== 1'b0)
            reportMismatch("dmemWriteEnable", 32'(dmemWriteEnable), 32'd0);
        if (halt !== 1'b0)
            reportMismatch("halt", 32'(halt), 32'd0);
        if (imemAddr !== `RESET_PC)
            reportMismatch("imemAddr", imemAddr, `RESET_PC);
        while (halt !== 1'b1)
            @(negedge clk);
        if (storeIdx != expAddr.size())
        begin
            otherErrs++;
            $display("halt rose after %0d of %0d expected stores", storeIdx, expAddr.size());
        end
        repeat (10)
        begin
            @(negedge clk);
            if (halt !== 1'b1)
            begin
                otherErrs++;
                $display("halt dropped at %0t", $time);
            end
        end
        finished = 1'b1;
        $display("stores %0d of %0d, value errors %0d, other errors %0d",
                 storeIdx, expAddr.size(), valueErrs, otherErrs);
        if (valueErrs + otherErrs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // watchdog, 40 cycles per model step on top of reset
    initial
    begin
        wait (modelReady);
        repeat (steps * 40 + 5) @(posedge clk);
        if (!finished)
        begin
            $display("timeout: halt not reached within %0d cycles", steps * 40 + 5);
            $display("stores %0d of %0d, value errors %0d, other errors %0d",
                     storeIdx, expAddr.size(), valueErrs, otherErrs + 1);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule
